//--- bench/tb_tests.svh
  // encoders take each field from the low bits of its argument
  function automatic logic [31:0] r_type(input int f7, f3, rd, rs1, rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input int op, f3, rd, rs1, imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] s_type(input int f3, rs1, rs2, imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input int f3, rs1, rs2, off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input int op, rd, imm);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] j_type(input int rd, off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  // addi sign extends its immediate, so round the lui part up
  task automatic load_const(input int rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    put(u_type('h37, rd, hi >> 12), 1'b1, rd, {hi[31:12], 12'h000});
    put(i_type('h13, 0, rd, rd, value), 1'b1, rd, value);
  endtask

  task automatic test_reset();
    int errs_before;
    errs_before = errors;
    new_program();
    reset_dut();
    check("pc", pc, 32'h0);
    check("retire", {31'b0, retire}, 32'h0);
    check("wb_en", {31'b0, wb_en}, 32'h0);
    // run stays low so the pc holds
    repeat (3) @(negedge clk);
    check("pc", pc, 32'h0);
    check("retire", {31'b0, retire}, 32'h0);
    report_test("reset", errs_before);
  endtask

  task automatic test_alu();
    int          ia;
    int          ib;
    int          c;
    int          sh;
    logic [31:0] a;
    logic [31:0] b;
    ia = $random(seed) % 2048;
    ib = $random(seed) % 2048;
    c  = $random(seed) % 2048;
    sh = $random(seed) & 31;
    a  = ia;
    b  = ib;
    new_program();
    put(i_type('h13, 0, 1, 0, ia), 1'b1, 1, a);
    put(i_type('h13, 0, 2, 0, ib), 1'b1, 2, b);
    put(i_type('h13, 0, 5, 0, sh), 1'b1, 5, sh);
    put(r_type(0, 0, 3, 1, 2), 1'b1, 3, a + b);
    put(r_type(32, 0, 3, 1, 2), 1'b1, 3, a - b);
    put(r_type(0, 4, 3, 1, 2), 1'b1, 3, a ^ b);
    put(r_type(0, 6, 3, 1, 2), 1'b1, 3, a | b);
    put(r_type(0, 7, 3, 1, 2), 1'b1, 3, a & b);
    put(r_type(0, 1, 3, 1, 5), 1'b1, 3, a << sh);
    put(r_type(0, 5, 3, 1, 5), 1'b1, 3, a >> sh);
    put(r_type(32, 5, 3, 1, 5), 1'b1, 3, $signed(a) >>> sh);
    // immediate forms, c already sign extended
    put(i_type('h13, 0, 4, 1, c), 1'b1, 4, a + c);
    put(i_type('h13, 4, 4, 1, c), 1'b1, 4, a ^ c);
    put(i_type('h13, 6, 4, 1, c), 1'b1, 4, a | c);
    put(i_type('h13, 7, 4, 1, c), 1'b1, 4, a & c);
    put(i_type('h13, 1, 4, 1, sh), 1'b1, 4, a << sh);
    put(i_type('h13, 5, 4, 1, sh), 1'b1, 4, a >> sh);
    put(i_type('h13, 5, 4, 1, 1024 + sh), 1'b1, 4, $signed(a) >>> sh);
    // x0 gets a write request but still reads as zero
    put(i_type('h13, 0, 0, 0, ia), 1'b1, 0, a);
    put(r_type(0, 0, 6, 0, 2), 1'b1, 6, b);
    run_program("alu");
  endtask

  task automatic test_memory();
    logic [31:0] w;
    logic [31:0] v;
    logic [31:0] m;
    w = $random(seed);
    v = $random(seed);
    // word at 0x104 after sw w, sh v to the upper half, sb v to byte 1
    m = {v[15:0], v[7:0], w[7:0]};
    new_program();
    put(i_type('h13, 0, 1, 0, 'h100), 1'b1, 1, 32'h100);
    load_const(2, w);
    load_const(4, v);
    put(s_type(2, 1, 2, 0), 1'b0, 0, 0);
    put(i_type('h03, 2, 3, 1, 0), 1'b1, 3, w);
    put(s_type(2, 1, 2, 4), 1'b0, 0, 0);
    put(s_type(1, 1, 4, 6), 1'b0, 0, 0);
    put(s_type(0, 1, 4, 5), 1'b0, 0, 0);
    put(i_type('h03, 2, 5, 1, 4), 1'b1, 5, m);
    put(i_type('h03, 1, 6, 1, 6), 1'b1, 6, {{16{m[31]}}, m[31:16]});
    put(i_type('h03, 5, 7, 1, 6), 1'b1, 7, {16'h0, m[31:16]});
    put(i_type('h03, 0, 8, 1, 5), 1'b1, 8, {{24{m[15]}}, m[15:8]});
    put(i_type('h03, 4, 9, 1, 7), 1'b1, 9, {24'h0, m[31:24]});
    put(i_type('h03, 1, 10, 1, 4), 1'b1, 10, {{16{m[15]}}, m[15:0]});
    put(i_type('h03, 0, 11, 1, 4), 1'b1, 11, {{24{w[7]}}, w[7:0]});
    run_program("memory");
  endtask

  // the taken form skips one word, the other falls through to pc+4
  task automatic branch_pair(input int f3, t1, t2, n1, n2);
    put(b_type(f3, t1, t2, 8), 1'b0, 0, 0);
    emit(i_type('h13, 0, 9, 0, 1));
    put(b_type(f3, n1, n2, 8), 1'b0, 0, 0);
    put(i_type('h13, 0, 10, 0, f3), 1'b1, 10, f3);
  endtask

  task automatic test_branches();
    new_program();
    // x1 = x3 = -5, x2 = 3
    put(i_type('h13, 0, 1, 0, -5), 1'b1, 1, 32'hffff_fffb);
    put(i_type('h13, 0, 2, 0, 3), 1'b1, 2, 32'h3);
    put(i_type('h13, 0, 3, 0, -5), 1'b1, 3, 32'hffff_fffb);
    branch_pair(0, 1, 3, 1, 2);  // beq
    branch_pair(1, 1, 2, 1, 3);  // bne
    branch_pair(4, 1, 2, 2, 1);  // blt
    branch_pair(5, 2, 1, 1, 2);  // bge
    branch_pair(6, 2, 1, 1, 2);  // bltu
    branch_pair(7, 1, 2, 2, 1);  // bgeu
    run_program("branches");
  endtask

  task automatic test_upper_jump();
    logic [31:0] u;
    u = $random(seed);
    new_program();
    put(u_type('h37, 1, u), 1'b1, 1, {u[19:0], 12'h000});
    // auipc sits at pc 4
    put(u_type('h17, 2, u), 1'b1, 2, {u[19:0], 12'h000} + 32'd4);
    // jal at pc 8 lands on pc 20, link is 12
    put(j_type(3, 12), 1'b1, 3, 32'd12);
    emit(i_type('h13, 0, 9, 0, 1));
    emit(i_type('h13, 0, 9, 0, 2));
    put(i_type('h13, 0, 4, 3, 1), 1'b1, 4, 32'd13);
    run_program("upper_jump");
  endtask

  task automatic test_unsupported();
    new_program();
    put(i_type('h13, 0, 1, 0, 100), 1'b1, 1, 32'd100);
    // ecall, jalr and slt retire as no-ops
    put(32'h0000_0073, 1'b0, 0, 0);
    put(i_type('h67, 0, 2, 1, 0), 1'b0, 0, 0);
    put(r_type(0, 2, 3, 1, 1), 1'b0, 0, 0);
    // x2 and x3 were never written
    put(r_type(0, 0, 4, 2, 3), 1'b1, 4, 32'h0);
    run_program("unsupported");
  endtask

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int CLK_PERIOD  = 4;
  localparam int PROG_WORDS  = 64;
  localparam int NUM_TESTS   = 6;
  // one full program per test plus reset and some slack
  localparam int TEST_CYCLES = PROG_WORDS + 8;
  localparam int WATCHDOG_NS = 2 * NUM_TESTS * TEST_CYCLES * CLK_PERIOD;
  localparam int RETIRE_WAIT = 8;
  localparam logic [31:0] NOP = 32'h0000_0013;

  // one expected retirement
  typedef struct packed {
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

  logic        clk;
  logic        rst_n;
  logic        run;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        retire;
  logic [31:0] retire_pc;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] prog [PROG_WORDS];
  int          prog_len;
  retire_t     exp_q [$];
  int          errors;
  int          checks;
  int          tests_run;
  integer      seed;

  rv_core #(
    .RAM_WORDS (256),
    .RESET_PC  (32'h0)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .pc        (pc),
    .instr     (instr),
    .retire    (retire),
    .retire_pc (retire_pc),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  // instruction ROM, fetches past the program see a nop
  assign instr = (pc[31:8] == 24'h0) ? prog[pc[7:2]] : NOP;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
      errors++;
    end
  endtask

  task automatic reset_dut();
    @(negedge clk);
    run   = 1'b0;
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic new_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i[5:0]] = NOP;
    end
    prog_len = 0;
    exp_q.delete();
  endtask

  task automatic emit(input logic [31:0] ins);
    prog[prog_len[5:0]] = ins;
    prog_len++;
  endtask

  // instruction that must retire next, at its own address
  task automatic put(input logic [31:0] ins, input bit en, input int rd,
                     input logic [31:0] data);
    retire_t r;
    r.pc    = prog_len * 4;
    r.wb_en = en;
    r.rd    = rd[4:0];
    r.data  = data;
    exp_q.push_back(r);
    emit(ins);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // reset, then retire until every expected record has been seen
  task automatic run_program(input string name);
    retire_t want;
    int      errs_before;
    int      waited;
    errs_before = errors;
    reset_dut();
    run = 1'b1;
    while (exp_q.size() > 0) begin
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!retire && waited < RETIRE_WAIT);
      if (!retire) begin
        $display("%s: no retire pulse seen for %0d cycles", name, waited);
        errors++;
        break;
      end
      want = exp_q.pop_front();
      check("retire_pc", retire_pc, want.pc);
      check("wb_en", {31'b0, wb_en}, {31'b0, want.wb_en});
      if (want.wb_en) begin
        check("wb_rd", {27'b0, wb_rd}, {27'b0, want.rd});
        check("wb_data", wb_data, want.data);
      end
    end
    run = 1'b0;
    report_test(name, errs_before);
  endtask

  `include "tb_tests.svh"

  initial begin
    rst_n     = 1'b0;
    run       = 1'b0;
    seed      = 32'hccf8;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    new_program();
    test_reset();
    test_alu();
    test_memory();
    test_branches();
    test_upper_jump();
    test_unsupported();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+bench
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_data_ram.sv
hw/rv_core.sv
bench/tb_rv_core.sv

//--- hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::decode_t dec,
  input  logic [31:0]     pc,
  output rv_pkg::exec_t   ex
);
  import rv_pkg::*;

  logic [31:0] res;
  logic [4:0]  shamt;
  logic        taken;

  assign shamt = dec.op2[4:0];

  always_comb begin
    case (dec.alu_cmd)
      ADD: res = dec.op1 + dec.op2;
      SUB: res = dec.op1 - dec.op2;
      XOR: res = dec.op1 ^ dec.op2;
      OR:  res = dec.op1 | dec.op2;
      AND: res = dec.op1 & dec.op2;
      SLL: res = dec.op1 << shamt;
      SRL: res = dec.op1 >> shamt;
      SRA: res = $signed(dec.op1) >>> shamt;
      EQ:  res = {31'b0, dec.op1 == dec.op2};
      NE:  res = {31'b0, dec.op1 != dec.op2};
      LT:  res = {31'b0, $signed(dec.op1) < $signed(dec.op2)};
      GE:  res = {31'b0, $signed(dec.op1) >= $signed(dec.op2)};
      LTU: res = {31'b0, dec.op1 < dec.op2};
      GEU: res = {31'b0, dec.op1 >= dec.op2};
      default: res = 32'h0;
    endcase
  end

  assign taken = dec.is_branch && res[0];

  // next pc select
  always_comb begin
    ex.alu_res = res;
    ex.link    = pc + 32'd4;
    if (taken) begin
      ex.next_pc = pc + dec.branch_off;
    end else if (dec.is_jal) begin
      // jump target already summed as imm_j + pc
      ex.next_pc = res;
    end else begin
      ex.next_pc = pc + 32'd4;
    end
  end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter int          RAM_WORDS = 256,
  parameter logic [31:0] RESET_PC  = 32'h0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        run,
  output logic [31:0] pc,
  input  logic [31:0] instr,
  output logic        retire,
  output logic [31:0] retire_pc,
  output logic        wb_en,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data
);
  import rv_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  decode_t       dec;
  exec_t         ex;
  logic [4:0]    rs1_addr;
  logic [4:0]    rs2_addr;
  logic [31:0]   rs1_data;
  logic [31:0]   rs2_data;
  logic          lsu_rf_we;
  logic          rf_we;
  logic [4:0]    rf_rd;
  logic [31:0]   rf_wd;
  logic [AW-1:0] ram_addr;
  logic [3:0]    lsu_be;
  logic [3:0]    ram_be;
  logic [31:0]   ram_wdata;
  logic [31:0]   ram_rdata;

  // nothing commits while stopped
  assign rf_we  = run & lsu_rf_we;
  assign ram_be = lsu_be & {4{run}};

  rv_decoder u_decoder (
    .instr    (instr),
    .pc       (pc),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .wd       (rf_wd)
  );

  rv_alu u_alu (
    .dec (dec),
    .pc  (pc),
    .ex  (ex)
  );

  rv_lsu #(.RAM_WORDS(RAM_WORDS)) u_lsu (
    .dec       (dec),
    .ex        (ex),
    .ram_addr  (ram_addr),
    .ram_be    (lsu_be),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .rf_we     (lsu_rf_we),
    .rf_rd     (rf_rd),
    .rf_wd     (rf_wd)
  );

  rv_data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
    .clk   (clk),
    .addr  (ram_addr),
    .be    (ram_be),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  // pc and retire flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= RESET_PC;
      retire <= 1'b0;
      wb_en  <= 1'b0;
    end else begin
      retire <= run;
      wb_en  <= run & lsu_rf_we;
      if (run) begin
        pc <= ex.next_pc;
      end
    end
  end

  // observation of the instruction just retired
  always_ff @(posedge clk) begin
    if (run) begin
      retire_pc <= pc;
      wb_rd     <= rf_rd;
      wb_data   <= rf_wd;
    end
  end

endmodule

//--- hw/rv_data_ram.sv
`timescale 1ns/1ps

module rv_data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                         clk,
  input  logic [$clog2(RAM_WORDS)-1:0] addr,
  input  logic [3:0]                   be,
  input  logic [31:0]                  wdata,
  output logic [31:0]                  rdata
);

  logic [31:0] mem [RAM_WORDS];

  // one enable per byte lane
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  assign rdata = mem[addr];

endmodule

//--- hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  logic [31:0]     instr,
  input  logic [31:0]     pc,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  input  logic [31:0]     rs1_data,
  input  logic [31:0]     rs2_data,
  output rv_pkg::decode_t dec
);
  import rv_pkg::*;

  instr_fields_t f;
  alu_cmd_e      alu_cmd;
  mem_access_e   access;
  logic          known;

  // field split
  assign f.opcode = opcode_e'(instr[6:0]);
  assign f.rd     = instr[11:7];
  assign f.rs1    = instr[19:15];
  assign f.rs2    = instr[24:20];
  assign f.funct3 = instr[14:12];
  assign f.funct7 = instr[31:25];
  assign f.imm_i  = instr[31:20];
  assign f.imm_s  = {instr[31:25], instr[11:7]};
  assign f.imm_b  = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign f.imm_u  = {instr[31:12], 12'h000};
  assign f.imm_j  = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign rs1_addr = f.rs1;
  assign rs2_addr = f.rs2;

  // full pattern match on funct7, funct3 and opcode
  always_comb begin
    known   = 1'b1;
    alu_cmd = ADD;
    access  = NONE;
    casez ({f.funct7, f.funct3, f.opcode})
      {7'b0000000, 3'b000, OP}, {7'b???????, 3'b000, OP_IMM}: alu_cmd = ADD;
      {7'b0100000, 3'b000, OP}:                              alu_cmd = SUB;
      {7'b0000000, 3'b100, OP}, {7'b???????, 3'b100, OP_IMM}: alu_cmd = XOR;
      {7'b0000000, 3'b110, OP}, {7'b???????, 3'b110, OP_IMM}: alu_cmd = OR;
      {7'b0000000, 3'b111, OP}, {7'b???????, 3'b111, OP_IMM}: alu_cmd = AND;
      {7'b0000000, 3'b001, OP}, {7'b0000000, 3'b001, OP_IMM}: alu_cmd = SLL;
      {7'b0000000, 3'b101, OP}, {7'b0000000, 3'b101, OP_IMM}: alu_cmd = SRL;
      {7'b0100000, 3'b101, OP}, {7'b0100000, 3'b101, OP_IMM}: alu_cmd = SRA;
      {7'b???????, 3'b000, BRANCH}: alu_cmd = EQ;
      {7'b???????, 3'b001, BRANCH}: alu_cmd = NE;
      {7'b???????, 3'b100, BRANCH}: alu_cmd = LT;
      {7'b???????, 3'b101, BRANCH}: alu_cmd = GE;
      {7'b???????, 3'b110, BRANCH}: alu_cmd = LTU;
      {7'b???????, 3'b111, BRANCH}: alu_cmd = GEU;
      {7'b???????, 3'b000, LOAD}:   access = LB;
      {7'b???????, 3'b001, LOAD}:   access = LH;
      {7'b???????, 3'b010, LOAD}:   access = LW;
      {7'b???????, 3'b100, LOAD}:   access = LBU;
      {7'b???????, 3'b101, LOAD}:   access = LHU;
      {7'b???????, 3'b000, STORE}:  access = SB;
      {7'b???????, 3'b001, STORE}:  access = SH;
      {7'b???????, 3'b010, STORE}:  access = SW;
      // upper immediates and jump use the adder
      {10'b??????????, LUI}, {10'b??????????, AUIPC}, {10'b??????????, JAL}: ;
      default: known = 1'b0;
    endcase
  end

  // operand select, anything unrecognised becomes a no-op
  always_comb begin
    dec            = '0;
    dec.alu_cmd    = alu_cmd;
    dec.access     = access;
    dec.store_data = rs2_data;
    dec.branch_off = 32'(signed'(f.imm_b));
    dec.rd         = f.rd;
    if (known) begin
      case (f.opcode)
        OP: begin
          dec.op1   = rs1_data;
          dec.op2   = rs2_data;
          dec.wb_en = 1'b1;
        end
        OP_IMM, LOAD: begin
          dec.op1   = rs1_data;
          dec.op2   = 32'(signed'(f.imm_i));
          dec.wb_en = 1'b1;
        end
        STORE: begin
          dec.op1 = rs1_data;
          dec.op2 = 32'(signed'(f.imm_s));
        end
        BRANCH: begin
          dec.op1       = rs1_data;
          dec.op2       = rs2_data;
          dec.is_branch = 1'b1;
        end
        LUI: begin
          dec.op1   = f.imm_u;
          dec.wb_en = 1'b1;
        end
        AUIPC: begin
          dec.op1   = f.imm_u;
          dec.op2   = pc;
          dec.wb_en = 1'b1;
        end
        JAL: begin
          dec.op1    = 32'(signed'(f.imm_j));
          dec.op2    = pc;
          dec.is_jal = 1'b1;
          dec.wb_en  = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hw/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu #(
  parameter int RAM_WORDS = 256
) (
  input  rv_pkg::decode_t              dec,
  input  rv_pkg::exec_t                ex,
  output logic [$clog2(RAM_WORDS)-1:0] ram_addr,
  output logic [3:0]                   ram_be,
  output logic [31:0]                  ram_wdata,
  input  logic [31:0]                  ram_rdata,
  output logic                         rf_we,
  output logic [4:0]                   rf_rd,
  output logic [31:0]                  rf_wd
);
  import rv_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  logic [1:0]  lane;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic [31:0] ld_val;
  logic        is_load;

  assign ram_addr = ex.alu_res[AW+1:2];
  assign lane     = ex.alu_res[1:0];
  assign ld_byte  = ram_rdata[{lane, 3'b000} +: 8];
  assign ld_half  = ram_rdata[{lane[1], 4'b0000} +: 16];
  assign is_load  = dec.access inside {LB, LH, LW, LBU, LHU};

  // store lanes
  always_comb begin
    ram_be    = 4'b0000;
    ram_wdata = dec.store_data;
    case (dec.access)
      SB: begin
        ram_be    = 4'b0001 << lane;
        ram_wdata = {4{dec.store_data[7:0]}};
      end
      SH: begin
        ram_be    = 4'b0011 << {lane[1], 1'b0};
        ram_wdata = {2{dec.store_data[15:0]}};
      end
      SW: ram_be = 4'b1111;
      default: ;
    endcase
  end

  // load extract and extend
  always_comb begin
    case (dec.access)
      LB:  ld_val = 32'(signed'(ld_byte));
      LH:  ld_val = 32'(signed'(ld_half));
      LBU: ld_val = {24'h0, ld_byte};
      LHU: ld_val = {16'h0, ld_half};
      default: ld_val = ram_rdata;
    endcase
  end

  assign rf_we = dec.wb_en;
  assign rf_rd = dec.rd;
  assign rf_wd = is_load ? ld_val : (dec.is_jal ? ex.link : ex.alu_res);

  // address from execute against access size from decode
  always_comb begin
    a_aligned: assert final (!(dec.access inside {LH, LHU, SH}) && !(dec.access inside {LW, SW})
                             || (dec.access inside {LH, LHU, SH}) && !lane[0]
                             || (dec.access inside {LW, SW}) && lane == 2'b00)
      else $error("misaligned %s at %h", dec.access.name(), ex.alu_res);
  end

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

  // major opcodes accepted by the decoder
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    XOR,
    OR,
    AND,
    SLL,
    SRL,
    SRA,
    // compares, result is 0 or 1
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU
  } alu_cmd_e;

  typedef enum logic [3:0] {
    NONE,
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } mem_access_e;

  // raw fields, immediates not yet extended
  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [12:0] imm_b;
    logic [31:0] imm_u;
    logic [20:0] imm_j;
  } instr_fields_t;

  typedef struct packed {
    alu_cmd_e    alu_cmd;
    mem_access_e access;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] store_data;
    logic [31:0] branch_off;
    logic        is_branch;
    logic        is_jal;
    logic [4:0]  rd;
    logic        wb_en;
  } decode_t;

  typedef struct packed {
    logic [31:0] alu_res;
    logic [31:0] next_pc;
    logic [31:0] link;
  } exec_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        we,
  input  logic [4:0]  rd,
  input  logic [31:0] wd
);

  // x1..x31, x0 has no storage
  logic [31:0] regs [31:1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1_addr == 5'd0) ? 32'h0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'h0 : regs[rs2_addr];

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 -f flist.f --top-module tb_rv_core -o tb_rv_core \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_rv_core > sim.log 2>&1 || echo "simulator returned a nonzero status"
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"
exit 0
